/* files.f */
design/rv_isa_pkg.sv
design/core_if_pkg.sv
design/instr_fetch.sv
design/decode_exec.sv
design/reg_file.sv
design/retire_log.sv
design/mini_core_wrapper.sv
tb/mini_core_asserts.sv
tb/tb_mini_core.sv

/* run.sh */
#!/bin/sh
# Build the mini core testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_mini_core -f files.f -o sim_mini_core \
  > build.log 2>&1 || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_mini_core +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

/* tb/tb_mini_core.sv */
// Testbench for the mini core wrapper.
// A random-latency instruction memory runs a fixed program while an ISA
// reference model checks every retire record, the fetch address and sleep.
`timescale 1ns/1ps
`default_nettype none

module tb_mini_core import core_if_pkg::*; ();

  localparam int          ILLEGAL_CNT_W  = 2;
  localparam int          TIMEOUT_CYCLES = 2000;
  localparam int          SLEEP_AFTER    = 15;
  localparam logic [31:0] HALT_PC        = 32'h0000_0074;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     fetch_enable;
  logic [31:0]              boot_addr;
  logic                     instr_req;
  logic                     instr_gnt;
  logic                     instr_rvalid;
  logic [31:0]              instr_addr;
  logic [31:0]              instr_rdata;
  logic                     retire_valid;
  retire_t                  retire;
  logic [ILLEGAL_CNT_W-1:0] illegal_count;
  logic                     core_sleep;

  logic [31:0] prog [64];
  logic [31:0] mregs [32];
  logic [31:0] model_pc;
  logic [31:0] pending_addr;
  logic        pending;
  logic        halt_seen;
  int          seed = 32'h243a_6046;
  int          gnt_wait;
  int          rvalid_wait;
  int          retired;
  int          illegal_seen;
  int          cycles;
  int          field_errors;
  int          other_errors;

  mini_core_wrapper #(
    .ILLEGAL_CNT_W ( ILLEGAL_CNT_W )
  ) UUT (
    .clk_i           ( clk           ),
    .rst_i           ( rst           ),
    .fetch_enable_i  ( fetch_enable  ),
    .boot_addr_i     ( boot_addr     ),
    .instr_req_o     ( instr_req     ),
    .instr_gnt_i     ( instr_gnt     ),
    .instr_rvalid_i  ( instr_rvalid  ),
    .instr_addr_o    ( instr_addr    ),
    .instr_rdata_i   ( instr_rdata   ),
    .retire_valid_o  ( retire_valid  ),
    .retire_o        ( retire        ),
    .illegal_count_o ( illegal_count ),
    .core_sleep_o    ( core_sleep    )
  );

  always #20 clk = ~clk;

  // Small assembler for the program image
  function automatic logic [31:0] rtype(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] itype(int f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] utype(int rd, int imm20);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  function automatic logic [31:0] btype(int f3, int rs1, int rs2, int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
  endfunction

  task automatic load_program();
    // Unused words are illegal and vary with the word address
    for (int i = 0; i < 64; i++) begin
      prog[i] = {i[24:0] ^ 25'h1a5_5a5a, 7'b0000000};
    end
    prog[0]  = utype(1, 'h12345);
    prog[1]  = itype(0, 1, 1, 'h678);
    prog[2]  = itype(0, 2, 0, -1);
    prog[3]  = itype(7, 3, 1, 'h0ff);
    prog[4]  = itype(6, 4, 3, 'h700);
    prog[5]  = itype(4, 5, 2, 'h555);
    prog[6]  = rtype(0, 0, 6, 1, 3);
    prog[7]  = rtype('h20, 0, 7, 3, 1);
    prog[8]  = rtype(0, 7, 8, 1, 2);
    prog[9]  = rtype(0, 6, 9, 3, 4);
    prog[10] = rtype(0, 4, 10, 5, 1);
    prog[11] = itype(0, 0, 1, 5);
    prog[12] = rtype(0, 0, 11, 0, 1);
    prog[13] = 32'hffff_ffff;
    prog[14] = itype(1, 13, 1, 1);
    prog[15] = rtype(1, 0, 14, 1, 2);
    prog[16] = btype(0, 3, 3, 8);
    prog[17] = itype(0, 15, 0, 1);
    prog[18] = btype(1, 3, 3, 8);
    prog[19] = btype(1, 1, 2, 8);
    prog[20] = itype(0, 16, 0, 2);
    // Counting loop with a backward branch
    prog[21] = itype(0, 20, 20, 1);
    prog[22] = itype(0, 21, 0, 3);
    prog[23] = btype(1, 20, 21, -8);
    prog[24] = btype(2, 1, 2, 8);
    prog[25] = utype(0, 'habcde);
    prog[26] = rtype(0, 6, 12, 0, 0);
    prog[27] = btype(0, 1, 2, 8);
    prog[28] = 32'h0000_0000;
    prog[29] = btype(0, 0, 0, 0);
  endtask

  task automatic check_field(string name, logic [31:0] exp, logic [31:0] act);
    assert (exp === act) else begin
      field_errors++;
      $display("error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Reference model step for one retired word
  task automatic check_retire();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] wdata;
    logic        we;
    logic        illegal;
    logic        taken;
    word    = prog[model_pc[7:2]];
    a       = mregs[word[19:15]];
    b       = mregs[word[24:20]];
    imm_i   = {{20{word[31]}}, word[31:20]};
    imm_b   = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    wdata   = '0;
    we      = 1'b1;
    illegal = 1'b0;
    taken   = 1'b0;
    case (word[6:0])
      7'h37: wdata = {word[31:12], 12'h000};
      7'h13: begin
        case (word[14:12])
          3'd0: wdata = a + imm_i;
          3'd4: wdata = a ^ imm_i;
          3'd6: wdata = a | imm_i;
          3'd7: wdata = a & imm_i;
          default: illegal = 1'b1;
        endcase
      end
      7'h33: begin
        case ({word[31:25], word[14:12]})
          10'h000: wdata = a + b;
          10'h100: wdata = a - b;
          10'h004: wdata = a ^ b;
          10'h006: wdata = a | b;
          10'h007: wdata = a & b;
          default: illegal = 1'b1;
        endcase
      end
      7'h63: begin
        we = 1'b0;
        if (word[14:12] == 3'd0) begin
          taken = (a == b);
        end else if (word[14:12] == 3'd1) begin
          taken = (a != b);
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      we = 1'b0;
      illegal_seen++;
    end
    check_field("retire_o.pc", model_pc, retire.pc);
    check_field("retire_o.instr", word, retire.instr);
    check_field("retire_o.rd", 32'(word[11:7]), 32'(retire.rd));
    check_field("retire_o.we", 32'(we), 32'(retire.we));
    check_field("retire_o.illegal", 32'(illegal), 32'(retire.illegal));
    if (we) begin
      check_field("retire_o.wdata", wdata, retire.wdata);
    end
    if (we && word[11:7] != 5'd0) begin
      mregs[word[11:7]] = wdata;
    end
    check_field("illegal_count_o", illegal_seen % (1 << ILLEGAL_CNT_W), 32'(illegal_count));
    if (model_pc == HALT_PC) begin
      halt_seen = 1'b1;
    end
    model_pc = taken ? model_pc + imm_b : model_pc + 32'd4;
    retired++;
  endtask

  // Instruction memory, one response per grant
  always @(posedge clk) begin
    #2;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    if (rst) begin
      pending = 1'b0;
    end else if (pending) begin
      if (rvalid_wait == 0) begin
        instr_rvalid = 1'b1;
        instr_rdata  = prog[pending_addr[7:2]];
        pending      = 1'b0;
      end else begin
        rvalid_wait--;
      end
    end else if (instr_req) begin
      if (gnt_wait == 0) begin
        instr_gnt    = 1'b1;
        pending      = 1'b1;
        pending_addr = instr_addr;
        rvalid_wait  = $unsigned($random(seed)) % 3;
        gnt_wait     = $unsigned($random(seed)) % 4;
      end else begin
        gnt_wait--;
      end
    end
  end

  // Retire records and the requested address are stable at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (retire_valid) begin
        check_retire();
      end
      if (instr_req) begin
        check_field("instr_addr_o", model_pc, instr_addr);
      end
    end
  end

  task automatic finish_run();
    int assert_errors;
    assert_errors = UUT.proto_asserts.addr_fails + UUT.proto_asserts.rvalid_fails +
                    UUT.proto_asserts.retire_fails + UUT.proto_asserts.sleep_fails;
    $display("errors: %0d field, %0d protocol assertion, %0d other",
             field_errors, assert_errors, other_errors);
    if (field_errors + assert_errors + other_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      other_errors++;
      $display("timed out after %0d cycles before the program finished", cycles);
      finish_run();
    end
  end

  initial begin
    rst          = 1'b1;
    fetch_enable = 1'b0;
    boot_addr    = 32'h0000_0000;
    instr_gnt    = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata  = '0;
    pending      = 1'b0;
    pending_addr = '0;
    gnt_wait     = 1;
    rvalid_wait  = 0;
    model_pc     = 32'h0000_0000;
    halt_seen    = 1'b0;
    retired      = 0;
    illegal_seen = 0;
    cycles       = 0;
    field_errors = 0;
    other_errors = 0;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    load_program();
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;
    fetch_enable = 1'b1;

    // Pause fetch mid-program, then resume
    while (retired < SLEEP_AFTER) begin
      @(posedge clk);
    end
    #2;
    fetch_enable = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (!core_sleep);
    repeat (6) begin
      @(posedge clk);
      #2;
      assert (core_sleep && !instr_req) else begin
        other_errors++;
        $display("core woke or requested while fetch was disabled at %0t ns", $time);
      end
    end
    fetch_enable = 1'b1;

    while (!halt_seen) begin
      @(posedge clk);
    end
    #2;
    fetch_enable = 1'b0;
    do begin
      @(posedge clk);
      #2;
    end while (!core_sleep);
    finish_run();
  end

endmodule

`default_nettype wire

/* tb/mini_core_asserts.sv */
// Concurrent checks on the instruction port, the retire timing and sleep.
// Bound into every mini_core_wrapper instance.
`timescale 1ns/1ps
`default_nettype none

module mini_core_asserts (
  input logic        clk_i,
  input logic        rst_i,
  input logic        req_i,
  input logic [31:0] addr_i,
  input logic        gnt_i,
  input logic        rvalid_i,
  input logic        retire_valid_i,
  input logic        sleep_i
);

  logic granted_q;
  int   addr_fails = 0;
  int   rvalid_fails = 0;
  int   retire_fails = 0;
  int   sleep_fails = 0;

  // One granted request waiting for its response
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      granted_q <= 1'b0;
    end else if (req_i && gnt_i) begin
      granted_q <= 1'b1;
    end else if (rvalid_i) begin
      granted_q <= 1'b0;
    end
  end

  addr_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i && !gnt_i |=> req_i && $stable(addr_i))
    else begin
      addr_fails++;
      $error("instruction request dropped or address changed before grant");
    end

  rvalid_granted_a: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> granted_q)
    else begin
      rvalid_fails++;
      $error("rvalid without an outstanding grant");
    end

  retire_timing_a: assert property (@(posedge clk_i) disable iff (rst_i)
    retire_valid_i == $past(rvalid_i))
    else begin
      retire_fails++;
      $error("retire not exactly one cycle after rvalid");
    end

  // A sleeping core must not raise a new request on the next cycle
  sleep_no_req_a: assert property (@(posedge clk_i) disable iff (rst_i)
    sleep_i |=> !req_i)
    else begin
      sleep_fails++;
      $error("instruction request raised while the core was asleep");
    end

endmodule

bind mini_core_wrapper mini_core_asserts proto_asserts (
  .clk_i          ( clk_i          ),
  .rst_i          ( rst_i          ),
  .req_i          ( instr_req_o    ),
  .addr_i         ( instr_addr_o   ),
  .gnt_i          ( instr_gnt_i    ),
  .rvalid_i       ( instr_rvalid_i ),
  .retire_valid_i ( retire_valid_o ),
  .sleep_i        ( core_sleep_o   )
);

`default_nettype wire

/* design/mini_core_wrapper.sv */
// Top level of the mini core: fetch, decode/execute, register file
// and retire logger on one instruction port.
`timescale 1ns/1ps
`default_nettype none

module mini_core_wrapper import core_if_pkg::*; #(
  parameter int ILLEGAL_CNT_W = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_enable_i,
  input  logic [31:0]              boot_addr_i,

  // Instruction memory interface
  output logic                     instr_req_o,
  input  logic                     instr_gnt_i,
  input  logic                     instr_rvalid_i,
  output logic [31:0]              instr_addr_o,
  input  logic [31:0]              instr_rdata_i,

  // Retire port and status
  output logic                     retire_valid_o,
  output retire_t                  retire_o,
  output logic [ILLEGAL_CNT_W-1:0] illegal_count_o,
  output logic                     core_sleep_o
);

  logic        fetch_valid;
  fetch_rsp_t  fetch_rsp;
  exec_res_t   exec_res;
  logic        fetch_idle;
  logic [4:0]  rs1_addr;
  logic [4:0]  rs2_addr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;

  instr_fetch fetch_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .exec_i         ( exec_res       ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_o        ( fetch_rsp      ),
    .idle_o         ( fetch_idle     )
  );

  decode_exec exec_i (
    .fetch_valid_i ( fetch_valid ),
    .fetch_i       ( fetch_rsp   ),
    .rs1_addr_o    ( rs1_addr    ),
    .rs2_addr_o    ( rs2_addr    ),
    .rs1_data_i    ( rs1_data    ),
    .rs2_data_i    ( rs2_data    ),
    .exec_o        ( exec_res    )
  );

  reg_file regs_i (
    .clk_i     ( clk_i          ),
    .rst_i     ( rst_i          ),
    .raddr_a_i ( rs1_addr       ),
    .raddr_b_i ( rs2_addr       ),
    .rdata_a_o ( rs1_data       ),
    .rdata_b_o ( rs2_data       ),
    .waddr_i   ( exec_res.rd    ),
    .wdata_i   ( exec_res.wdata ),
    .we_i      ( exec_res.we    )
  );

  retire_log #(
    .ILLEGAL_CNT_W ( ILLEGAL_CNT_W )
  ) retire_i (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .fetch_valid_i   ( fetch_valid     ),
    .fetch_i         ( fetch_rsp       ),
    .exec_i          ( exec_res        ),
    .idle_i          ( fetch_idle      ),
    .fetch_enable_i  ( fetch_enable_i  ),
    .retire_valid_o  ( retire_valid_o  ),
    .retire_o        ( retire_o        ),
    .illegal_count_o ( illegal_count_o ),
    .core_sleep_o    ( core_sleep_o    )
  );

endmodule

`default_nettype wire

/* design/retire_log.sv */
// Retire stage: one registered record per executed word,
// a wrapping count of illegal words and the core sleep flag.
`timescale 1ns/1ps
`default_nettype none

module retire_log import core_if_pkg::*; #(
  parameter int ILLEGAL_CNT_W = 8
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     fetch_valid_i,
  input  fetch_rsp_t               fetch_i,
  input  exec_res_t                exec_i,
  input  logic                     idle_i,
  input  logic                     fetch_enable_i,
  output logic                     retire_valid_o,
  output retire_t                  retire_o,
  output logic [ILLEGAL_CNT_W-1:0] illegal_count_o,
  output logic                     core_sleep_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      retire_valid_o  <= 1'b0;
      illegal_count_o <= '0;
    end else begin
      retire_valid_o <= fetch_valid_i;
      if (fetch_valid_i && exec_i.illegal) begin
        illegal_count_o <= illegal_count_o + ILLEGAL_CNT_W'(1);
      end
    end
  end

  // Record payload, qualified by retire_valid_o
  always_ff @(posedge clk_i) begin
    if (fetch_valid_i) begin
      retire_o.pc      <= fetch_i.pc;
      retire_o.instr   <= fetch_i.instr;
      retire_o.rd      <= exec_i.rd;
      retire_o.wdata   <= exec_i.wdata;
      retire_o.we      <= exec_i.we;
      retire_o.illegal <= exec_i.illegal;
    end
  end

  // Asleep once fetch is off and nothing is outstanding
  assign core_sleep_o = ~fetch_enable_i & idle_i;

endmodule

`default_nettype wire

/* design/reg_file.sv */
// Integer register file, 32 x 32 bits.
// Two combinational read ports and one write port; x0 reads as zero.
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [4:0]  raddr_a_i,
  input  logic [4:0]  raddr_b_i,
  output logic [31:0] rdata_a_o,
  output logic [31:0] rdata_b_o,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  input  logic        we_i
);

  logic [31:0] regs_q [32];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      // x0 keeps its reset value of zero
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* design/decode_exec.sv */
// Single-cycle decode and execute of the RV32I subset.
// Reads the register file combinationally and returns the write-back
// data, the illegal flag and the next pc.
`timescale 1ns/1ps
`default_nettype none

module decode_exec import rv_isa_pkg::*, core_if_pkg::*; (
  input  logic        fetch_valid_i,
  input  fetch_rsp_t  fetch_i,
  output logic [4:0]  rs1_addr_o,
  output logic [4:0]  rs2_addr_o,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output exec_res_t   exec_o
);

  instr_u      instr;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] result;
  logic        writes_rd;
  logic        legal;
  logic        taken;

  assign instr      = fetch_i.instr;
  assign rs1_addr_o = instr.r.rs1;
  assign rs2_addr_o = instr.r.rs2;

  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};

  always_comb begin
    result    = '0;
    writes_rd = 1'b0;
    legal     = 1'b0;
    taken     = 1'b0;
    case (instr.r.opcode)
      OPC_LUI: begin
        result    = imm_u;
        writes_rd = 1'b1;
        legal     = 1'b1;
      end
      // Immediate forms use the I view of the word
      OPC_OP_IMM: begin
        writes_rd = 1'b1;
        legal     = 1'b1;
        case (instr.i.funct3)
          FUNCT3_ADD_SUB: result = rs1_data_i + imm_i;
          FUNCT3_XOR:     result = rs1_data_i ^ imm_i;
          FUNCT3_OR:      result = rs1_data_i | imm_i;
          FUNCT3_AND:     result = rs1_data_i & imm_i;
          default: begin
            writes_rd = 1'b0;
            legal     = 1'b0;
          end
        endcase
      end
      // Register forms need funct7 as well
      OPC_OP: begin
        writes_rd = 1'b1;
        legal     = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          {7'h00, FUNCT3_ADD_SUB}:      result = rs1_data_i + rs2_data_i;
          {FUNCT7_SUB, FUNCT3_ADD_SUB}: result = rs1_data_i - rs2_data_i;
          {7'h00, FUNCT3_XOR}:          result = rs1_data_i ^ rs2_data_i;
          {7'h00, FUNCT3_OR}:           result = rs1_data_i | rs2_data_i;
          {7'h00, FUNCT3_AND}:          result = rs1_data_i & rs2_data_i;
          default: begin
            writes_rd = 1'b0;
            legal     = 1'b0;
          end
        endcase
      end
      OPC_BRANCH: begin
        case (instr.r.funct3)
          FUNCT3_BEQ: begin
            legal = 1'b1;
            taken = (rs1_data_i == rs2_data_i);
          end
          FUNCT3_BNE: begin
            legal = 1'b1;
            taken = (rs1_data_i != rs2_data_i);
          end
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
  end

  assign exec_o.rd           = instr.r.rd;
  assign exec_o.wdata        = result;
  assign exec_o.we           = fetch_valid_i & legal & writes_rd;
  assign exec_o.illegal      = ~legal;
  assign exec_o.branch_taken = taken;
  // Not-taken and illegal words fall through to pc + 4
  assign exec_o.next_pc      = taken ? fetch_i.pc + imm_b : fetch_i.pc + 32'd4;

endmodule

`default_nettype wire

/* design/instr_fetch.sv */
// Instruction fetch with one request in flight on the req/gnt/rvalid port.
// The pc loads the executed next_pc in the response cycle.
`timescale 1ns/1ps
`default_nettype none

module instr_fetch import core_if_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        fetch_enable_i,
  input  logic [31:0] boot_addr_i,
  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i,
  input  exec_res_t   exec_i,
  output logic        fetch_valid_o,
  output fetch_rsp_t  fetch_o,
  output logic        idle_o
);

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_WAIT
  } fetch_state_e;

  fetch_state_e state_q;
  logic [31:0]  pc_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= FETCH_IDLE;
      pc_q    <= boot_addr_i;
    end else begin
      case (state_q)
        FETCH_IDLE: begin
          if (fetch_enable_i) begin
            state_q <= FETCH_REQ;
          end
        end
        // Hold req and address until granted
        FETCH_REQ: begin
          if (instr_gnt_i) begin
            state_q <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (instr_rvalid_i) begin
            pc_q    <= exec_i.next_pc;
            state_q <= fetch_enable_i ? FETCH_REQ : FETCH_IDLE;
          end
        end
        default: state_q <= FETCH_IDLE;
      endcase
    end
  end

  assign instr_req_o   = (state_q == FETCH_REQ);
  assign instr_addr_o  = pc_q;

  // Response is consumed by execute in the rvalid cycle
  assign fetch_valid_o = (state_q == FETCH_WAIT) & instr_rvalid_i;
  assign fetch_o.pc    = pc_q;
  assign fetch_o.instr = instr_rdata_i;

  assign idle_o        = (state_q == FETCH_IDLE);

endmodule

`default_nettype wire

/* design/core_if_pkg.sv */
// Records passed between the fetch, execute and retire blocks,
// and the retire record seen at the core boundary.
`default_nettype none

package core_if_pkg;

  // Word returned by the instruction port with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } fetch_rsp_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        we;
    logic        illegal;
    logic        branch_taken;
    logic [31:0] next_pc;
  } exec_res_t;

  // One entry per executed word
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        we;
    logic        illegal;
  } retire_t;

endpackage

`default_nettype wire

/* design/rv_isa_pkg.sv */
// RV32I subset encodings used by the decoder.
// Opcodes, function codes and the two views of one instruction word.
`default_nettype none

package rv_isa_pkg;

  // Major opcodes of the executed subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // funct3 for the ALU forms
  localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_AND     = 3'b111;

  // funct3 for the branches
  localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
  localparam logic [2:0] FUNCT3_BNE     = 3'b001;

  localparam logic [6:0] FUNCT7_SUB     = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  // B and U immediates are sliced from the raw word bits
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

`default_nettype wire
